//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = conv_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
PASS_MSG  = Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

//--- conv_config.svh
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

////////////////////
// Datapath widths
////////////////////

// Pixel and weight width, both signed
`define CONV_DATA_WIDTH 16

// Taps in one 3x3 kernel
`define CONV_KERNEL_SIZE 9

// Twice the data width plus four guard bits for the nine-term sum
`define CONV_ACC_WIDTH 36

////////////////////
// Queue depths
////////////////////

`define CONV_KERNEL_FIFO_DEPTH 4
`define CONV_RESULT_FIFO_DEPTH 4

`endif

//--- conv_mac_pipe.sv
`default_nettype none

`include "conv_config.svh"

module conv_mac_pipe (
	input  logic              clk,
	input  logic              reset,
	input  logic              load_weights,
	input  logic              kernel_valid,
	output logic              kernel_ready,
	input  conv_pkg::kernel_t kernel_data,
	output logic              kernel_loaded,
	input  logic              win_valid,
	output logic              win_ready,
	input  conv_pkg::window_t win_data,
	input  conv_pkg::seq_t    win_seq,
	output logic              mac_valid,
	input  logic              mac_ready,
	output conv_pkg::result_t mac_data
);

	import conv_pkg::*;

	localparam int TAPS   = `CONV_KERNEL_SIZE;
	localparam int PROD_W = 2 * `CONV_DATA_WIDTH;
	localparam int ACC_W  = `CONV_ACC_WIDTH;

	kernel_t                   active_kernel;
	weight_t                   wgt_tap [TAPS];
	pixel_t                    pix_tap [TAPS];
	logic                      kernel_take;
	logic                      advance;
	logic                      win_accept;
	logic                      s1_valid;
	logic signed [PROD_W-1:0]  s1_prod [TAPS];
	seq_t                      s1_seq;
	logic signed [ACC_W-1:0]   tree_sum;
	logic                      s2_valid;
	result_t                   s2_result;

	////////////////////
	// Active kernel
	////////////////////

	assign kernel_ready = load_weights;
	assign kernel_take  = load_weights && kernel_valid;

	always_ff @(posedge clk) begin
		if (kernel_take) begin
			active_kernel <= kernel_data;
		end
	end

	// Sticky until reset
	always_ff @(posedge clk) begin
		if (reset) begin
			kernel_loaded <= 1'b0;
		end else if (kernel_take) begin
			kernel_loaded <= 1'b1;
		end
	end

	// Field to tap mapping
	always_comb begin
		wgt_tap[0] = active_kernel.w0;
		wgt_tap[1] = active_kernel.w1;
		wgt_tap[2] = active_kernel.w2;
		wgt_tap[3] = active_kernel.w3;
		wgt_tap[4] = active_kernel.w4;
		wgt_tap[5] = active_kernel.w5;
		wgt_tap[6] = active_kernel.w6;
		wgt_tap[7] = active_kernel.w7;
		wgt_tap[8] = active_kernel.w8;
		pix_tap[0] = win_data.p0;
		pix_tap[1] = win_data.p1;
		pix_tap[2] = win_data.p2;
		pix_tap[3] = win_data.p3;
		pix_tap[4] = win_data.p4;
		pix_tap[5] = win_data.p5;
		pix_tap[6] = win_data.p6;
		pix_tap[7] = win_data.p7;
		pix_tap[8] = win_data.p8;
	end

	////////////////////
	// Pipeline control
	////////////////////

	// Whole pipe moves when the output slot frees up
	assign advance    = !s2_valid || mac_ready;
	assign win_ready  = kernel_loaded && advance;
	assign win_accept = win_valid && win_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else if (advance) begin
			s1_valid <= win_accept;
			s2_valid <= s1_valid;
		end
	end

	// Stage 1: products, kernel sampled before any same-cycle load
	always_ff @(posedge clk) begin
		if (win_accept) begin
			for (int i = 0; i < TAPS; i++) begin
				s1_prod[i] <= pix_tap[i] * wgt_tap[i];
			end
			s1_seq <= win_seq;
		end
	end

	// Signed sum, each product sign-extended to accumulator width
	always_comb begin
		tree_sum = '0;
		for (int i = 0; i < TAPS; i++) begin
			tree_sum = tree_sum + s1_prod[i];
		end
	end

	// Stage 2: result register
	always_ff @(posedge clk) begin
		if (advance && s1_valid) begin
			s2_result.acc <= tree_sum;
			s2_result.seq <= s1_seq;
		end
	end

	assign mac_valid = s2_valid;
	assign mac_data  = s2_result;

endmodule

`default_nettype wire

//--- conv_pkg.sv
`default_nettype none

`include "conv_config.svh"

package conv_pkg;

	////////////////////
	// Scalar types
	////////////////////

	typedef logic signed [`CONV_DATA_WIDTH-1:0] pixel_t;
	typedef logic signed [`CONV_DATA_WIDTH-1:0] weight_t;

	// Tag carried with each window to its result
	typedef logic [15:0] seq_t;

	////////////////////
	// Packed bundles
	////////////////////

	// One 3x3 kernel, w0 is the first word received
	typedef struct packed {
		weight_t w0;
		weight_t w1;
		weight_t w2;
		weight_t w3;
		weight_t w4;
		weight_t w5;
		weight_t w6;
		weight_t w7;
		weight_t w8;
	} kernel_t;

	// One 3x3 window, p(i) pairs with w(i)
	typedef struct packed {
		pixel_t p0;
		pixel_t p1;
		pixel_t p2;
		pixel_t p3;
		pixel_t p4;
		pixel_t p5;
		pixel_t p6;
		pixel_t p7;
		pixel_t p8;
	} window_t;

	typedef struct packed {
		logic signed [`CONV_ACC_WIDTH-1:0] acc;
		seq_t                              seq;
	} result_t;

endpackage

`default_nettype wire

//--- conv_tb.sv
`default_nettype none

`include "conv_config.svh"

module conv_tb;

	import conv_pkg::*;

	localparam int ACC_W = `CONV_ACC_WIDTH;
	// Several times the combined length of all tests
	localparam int TIMEOUT_CYCLES = 4000;

	logic    clk;
	logic    reset;
	logic    w_valid;
	logic    w_ready;
	weight_t w_data;
	logic    load_weights;
	logic    kernel_loaded;
	logic    win_valid;
	logic    win_ready;
	window_t win_data;
	seq_t    win_seq;
	logic    res_valid;
	logic    res_ready;
	result_t res_data;

	// Model of the kernel queue and outstanding windows
	kernel_t kernel_q [$];
	result_t expect_q [$];
	kernel_t active_kernel;
	weight_t word_buf [9];
	int      word_idx;
	int      words_accepted;
	int      errors;
	int      checks;
	int      tests_run;
	int      tests_failed;
	int      test_start_errors;
	int      cycles;
	integer  seed;
	integer  ready_seed;
	seq_t    next_seq;
	string   test_name;
	logic    bp_done;

	conv_top conv_top_inst (
		.clk           (clk),
		.reset         (reset),
		.w_valid       (w_valid),
		.w_ready       (w_ready),
		.w_data        (w_data),
		.load_weights  (load_weights),
		.kernel_loaded (kernel_loaded),
		.win_valid     (win_valid),
		.win_ready     (win_ready),
		.win_data      (win_data),
		.win_seq       (win_seq),
		.res_valid     (res_valid),
		.res_ready     (res_ready),
		.res_data      (res_data)
	);

	always #50 clk = ~clk;

	// Nine-tap signed dot product, tap i pairs p(i) with w(i)
	function automatic logic signed [ACC_W-1:0] ref_dot(input kernel_t k, input window_t w);
		logic signed [ACC_W-1:0] sum;
		sum = '0;
		sum = sum + w.p0 * k.w0;
		sum = sum + w.p1 * k.w1;
		sum = sum + w.p2 * k.w2;
		sum = sum + w.p3 * k.w3;
		sum = sum + w.p4 * k.w4;
		sum = sum + w.p5 * k.w5;
		sum = sum + w.p6 * k.w6;
		sum = sum + w.p7 * k.w7;
		sum = sum + w.p8 * k.w8;
		return sum;
	endfunction

	////////////////////
	// Monitor and compare
	////////////////////

	always @(posedge clk) begin
		kernel_t built;
		result_t expected;
		if (reset) begin
			kernel_q.delete();
			expect_q.delete();
			word_idx = 0;
		end else begin
			if (w_valid && w_ready) begin
				word_buf[word_idx] = w_data;
				words_accepted++;
				if (word_idx == 8) begin
					// First word accepted lands in w0
					built = {word_buf[0], word_buf[1], word_buf[2], word_buf[3], word_buf[4],
						word_buf[5], word_buf[6], word_buf[7], word_buf[8]};
					kernel_q.push_back(built);
					word_idx = 0;
				end else begin
					word_idx++;
				end
			end
			// Window sees the old kernel if a load lands in the same cycle
			if (win_valid && win_ready) begin
				expected.acc = ref_dot(active_kernel, win_data);
				expected.seq = win_seq;
				expect_q.push_back(expected);
			end
			if (load_weights && kernel_q.size() > 0) begin
				active_kernel = kernel_q.pop_front();
			end
		end
	end

	always @(posedge clk) begin
		result_t head;
		if (!reset && res_valid && res_ready) begin
			checks++;
			assert (expect_q.size() > 0) else begin
				$display("Error in %s: result seq %0d arrived with no window outstanding",
					test_name, res_data.seq);
				errors++;
			end
			if (expect_q.size() > 0) begin
				head = expect_q.pop_front();
				assert (res_data == head) else begin
					$display("Fail %s: expected acc %0d seq %0d, actual acc %0d seq %0d",
						test_name, head.acc, head.seq, res_data.acc, res_data.seq);
					errors++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, test %s did not finish", cycles, test_name);
			$display("Regression failed");
			$finish;
		end
	end

	////////////////////
	// Stimulus tasks
	////////////////////

	// All tasks start and end just after a falling edge
	task automatic send_weight(input weight_t d);
		w_valid = 1'b1;
		w_data  = d;
		while (!w_ready) @(negedge clk);
		@(negedge clk);
		w_valid = 1'b0;
	endtask

	task automatic send_random_kernel();
		logic [31:0] r;
		for (int i = 0; i < 9; i++) begin
			r = $random(seed);
			send_weight(r[15:0]);
		end
	endtask

	task automatic send_window(input logic with_load);
		logic [31:0] r;
		window_t     w;
		w = '0;
		for (int i = 0; i < 9; i++) begin
			r = $random(seed);
			w = {w[127:0], r[15:0]};
		end
		win_valid = 1'b1;
		win_data  = w;
		win_seq   = next_seq;
		while (!win_ready) @(negedge clk);
		// Ready is known high here, so a load lands on the same edge
		load_weights = with_load;
		@(negedge clk);
		win_valid    = 1'b0;
		load_weights = 1'b0;
		next_seq++;
	endtask

	task automatic check_level(input string sig, input logic actual, input logic expected);
		checks++;
		assert (actual === expected) else begin
			$display("Fail %s: %s expected %0b, actual %0b", test_name, sig, expected, actual);
			errors++;
		end
	endtask

	// One-cycle load request, the kernel is active from the next edge
	task automatic load_kernel();
		load_weights = 1'b1;
		@(negedge clk);
		load_weights = 1'b0;
	endtask

	task automatic wait_drain();
		while (expect_q.size() != 0) @(negedge clk);
		repeat (2) @(negedge clk);
	endtask

	task automatic start_test(input string name);
		test_name         = name;
		test_start_errors = errors;
	endtask

	task automatic finish_test();
		tests_run++;
		if (errors == test_start_errors) begin
			$display("Test %s: ok", test_name);
		end else begin
			tests_failed++;
			$display("Test %s: %0d errors", test_name, errors - test_start_errors);
		end
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		int base;
		clk          = 1'b0;
		reset        = 1'b1;
		w_valid      = 1'b0;
		w_data       = '0;
		load_weights = 1'b0;
		win_valid    = 1'b0;
		win_data     = '0;
		win_seq      = '0;
		res_ready    = 1'b1;
		next_seq     = '0;
		seed         = 32'h957b;
		ready_seed   = seed ^ 32'h3c3c;
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		start_test("reset_state");
		check_level("kernel_loaded", kernel_loaded, 1'b0);
		check_level("win_ready", win_ready, 1'b0);
		check_level("res_valid", res_valid, 1'b0);
		check_level("w_ready", w_ready, 1'b1);
		finish_test();

		start_test("single_kernel");
		send_random_kernel();
		repeat (3) @(negedge clk);
		// Queued kernel alone does not make it active
		check_level("kernel_loaded", kernel_loaded, 1'b0);
		load_kernel();
		check_level("kernel_loaded", kernel_loaded, 1'b1);
		for (int i = 0; i < 20; i++) send_window(1'b0);
		wait_drain();
		finish_test();

		start_test("kernel_switch");
		for (int k = 0; k < 3; k++) send_random_kernel();
		repeat (3) @(negedge clk);
		load_kernel();
		for (int i = 0; i < 3; i++) send_window(1'b0);
		send_window(1'b1);
		for (int i = 0; i < 3; i++) send_window(1'b0);
		load_kernel();
		for (int i = 0; i < 3; i++) send_window(1'b0);
		wait_drain();
		finish_test();

		start_test("result_backpressure");
		bp_done = 1'b0;
		fork
			begin
				for (int i = 0; i < 30; i++) send_window(1'b0);
				bp_done = 1'b1;
			end
			begin
				logic [31:0] r;
				while (!bp_done) begin
					r = $random(ready_seed);
					res_ready = r[0];
					@(negedge clk);
				end
			end
		join
		res_ready = 1'b1;
		wait_drain();
		finish_test();

		start_test("full_kernel_fifo");
		base = words_accepted;
		fork
			for (int k = 0; k < 6; k++) send_random_kernel();
			begin
				// Four kernels queued and a fifth held in the weight buffer
				wait (words_accepted == base + 45);
				repeat (3) @(negedge clk);
				check_level("w_ready", w_ready, 1'b0);
				for (int k = 0; k < 6; k++) begin
					if (k == 5) begin
						wait (words_accepted == base + 54);
						repeat (3) @(negedge clk);
					end
					load_kernel();
					send_window(1'b0);
					send_window(1'b0);
				end
			end
		join
		wait_drain();
		finish_test();

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- conv_top.sv
`default_nettype none

`include "conv_config.svh"

module conv_top (
	input  logic              clk,
	input  logic              reset,
	// Weight stream
	input  logic              w_valid,
	output logic              w_ready,
	input  conv_pkg::weight_t w_data,
	// Kernel load
	input  logic              load_weights,
	output logic              kernel_loaded,
	// Window stream
	input  logic              win_valid,
	output logic              win_ready,
	input  conv_pkg::window_t win_data,
	input  conv_pkg::seq_t    win_seq,
	// Result stream
	output logic              res_valid,
	input  logic              res_ready,
	output conv_pkg::result_t res_data
);

	import conv_pkg::*;

	// Weight buffer to kernel FIFO
	logic    k_valid;
	logic    k_ready;
	kernel_t k_data;

	// Kernel FIFO to MAC pipe
	logic    kernel_valid;
	logic    kernel_ready;
	kernel_t kernel_data;

	// MAC pipe to result FIFO
	logic    mac_valid;
	logic    mac_ready;
	result_t mac_data;

	////////////////////
	// Kernel path
	////////////////////

	weight_buffer weight_buffer_inst (
		.clk     (clk),
		.reset   (reset),
		.w_valid (w_valid),
		.w_ready (w_ready),
		.w_data  (w_data),
		.k_valid (k_valid),
		.k_ready (k_ready),
		.k_data  (k_data)
	);

	sync_fifo #(
		.payload_t (kernel_t),
		.DEPTH     (`CONV_KERNEL_FIFO_DEPTH)
	) kernel_fifo_inst (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (k_valid),
		.in_ready  (k_ready),
		.in_data   (k_data),
		.out_valid (kernel_valid),
		.out_ready (kernel_ready),
		.out_data  (kernel_data)
	);

	////////////////////
	// Compute and output
	////////////////////

	conv_mac_pipe conv_mac_pipe_inst (
		.clk           (clk),
		.reset         (reset),
		.load_weights  (load_weights),
		.kernel_valid  (kernel_valid),
		.kernel_ready  (kernel_ready),
		.kernel_data   (kernel_data),
		.kernel_loaded (kernel_loaded),
		.win_valid     (win_valid),
		.win_ready     (win_ready),
		.win_data      (win_data),
		.win_seq       (win_seq),
		.mac_valid     (mac_valid),
		.mac_ready     (mac_ready),
		.mac_data      (mac_data)
	);

	sync_fifo #(
		.payload_t (result_t),
		.DEPTH     (`CONV_RESULT_FIFO_DEPTH)
	) result_fifo_inst (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (mac_valid),
		.in_ready  (mac_ready),
		.in_data   (mac_data),
		.out_valid (res_valid),
		.out_ready (res_ready),
		.out_data  (res_data)
	);

endmodule

`default_nettype wire

//--- sync_fifo.sv
`default_nettype none

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 4
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	assign in_ready  = (count != CNT_W'(DEPTH));
	assign out_valid = (count != '0);
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;

	// Head entry shown whenever not empty
	assign out_data = mem[rd_ptr];

	////////////////////
	// Storage
	////////////////////

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	////////////////////
	// Pointers and count
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leaves the count alone
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
conv_pkg.sv
sync_fifo.sv
weight_buffer.sv
conv_mac_pipe.sv
conv_top.sv
conv_tb.sv

//--- weight_buffer.sv
`default_nettype none

`include "conv_config.svh"

module weight_buffer (
	input  logic              clk,
	input  logic              reset,
	input  logic              w_valid,
	output logic              w_ready,
	input  conv_pkg::weight_t w_data,
	output logic              k_valid,
	input  logic              k_ready,
	output conv_pkg::kernel_t k_data
);

	import conv_pkg::*;

	localparam int TAPS  = `CONV_KERNEL_SIZE;
	localparam int CNT_W = $clog2(TAPS);

	weight_t          chain      [TAPS];
	weight_t          chain_next [TAPS];
	logic [CNT_W-1:0] count;
	logic             accept;
	logic             wrap;

	// Stall input only while a finished kernel waits for the FIFO
	assign w_ready = !(k_valid && !k_ready);
	assign accept  = w_valid && w_ready;
	assign wrap    = accept && (count == CNT_W'(TAPS - 1));

	////////////////////
	// Shift chain
	////////////////////

	// New word enters at the top, oldest drifts down to tap 0
	always_comb begin
		for (int i = 0; i < TAPS - 1; i++) begin
			chain_next[i] = chain[i + 1];
		end
		chain_next[TAPS - 1] = w_data;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			chain <= chain_next;
		end
	end

	// Words accepted for the current kernel
	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (wrap) begin
			count <= '0;
		end else if (accept) begin
			count <= count + 1'b1;
		end
	end

	////////////////////
	// Held kernel
	////////////////////

	// Captures the chain including the ninth word of this cycle
	always_ff @(posedge clk) begin
		if (wrap) begin
			k_data.w0 <= chain_next[0];
			k_data.w1 <= chain_next[1];
			k_data.w2 <= chain_next[2];
			k_data.w3 <= chain_next[3];
			k_data.w4 <= chain_next[4];
			k_data.w5 <= chain_next[5];
			k_data.w6 <= chain_next[6];
			k_data.w7 <= chain_next[7];
			k_data.w8 <= chain_next[8];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			k_valid <= 1'b0;
		end else if (wrap) begin
			k_valid <= 1'b1;
		end else if (k_ready) begin
			k_valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire
